/* sd_autotest.f */
rtl/autotest_pkg.sv
rtl/vector_loader.sv
rtl/uut_run_timer.sv
rtl/test_sequencer.sv
rtl/sd_autotest.sv
verification/sd_autotest_sva.sv
verification/tb_sd_autotest.sv

/* Makefile */
SIM      = verilator
VFLAGS   = --binary --timing --assert -j 0
TOP      = tb_sd_autotest
FILELIST = sd_autotest.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/tb_sd_autotest.sv */
// testbench for sd_autotest with sd card and uut models,
// five scenarios over five blocks, checks and summary
`timescale 1ns/1ps
`default_nettype none

module tb_sd_autotest;

  localparam int NUM_BLOCKS = 5;
  localparam int BLK_BYTES  = 512;
  localparam int TIMEOUT    = 200;
  localparam int WAIT_LIMIT = 20000;
  localparam int MODE_END   = 0;
  localparam int MODE_ERR   = 1;
  localparam int MODE_HANG  = 2;
  localparam int ACT_NONE   = 0;
  localparam int ACT_RESET  = 1;
  localparam int ACT_RBYTE  = 2;
  localparam int ACT_WBYTE  = 3;
  localparam int ACT_RBLOCK = 4;
  localparam int ACT_WBLOCK = 5;

  logic clk;
  logic rst;
  logic spi_busy_i;
  logic [7:0] spi_data_out_i;
  autotest_pkg::spi_cmd_t spi_cmd_o;
  logic [31:0] spi_block_addr_o;
  logic [7:0] spi_data_in_o;
  logic rst_uut_o;
  logic end_uut_i;
  logic err_uut_i;
  logic [31:0] uut_in_1_o;
  logic [31:0] uut_in_2_o;
  wire logic [31:0] uut_out_i;
  logic [31:0] error_count_o;
  logic halted_o;

  logic [7:0] card [0:NUM_BLOCKS-1][0:BLK_BYTES-1];
  logic [7:0] wr_mem [0:NUM_BLOCKS-1][0:BLK_BYTES-1];
  int wr_cnt [0:NUM_BLOCKS-1];
  int uut_mode [0:NUM_BLOCKS-1];
  logic [31:0] blk_in1 [0:NUM_BLOCKS-1];
  logic [31:0] blk_in2 [0:NUM_BLOCKS-1];
  logic [31:0] blk_exp [0:NUM_BLOCKS-1];

  int seed = 32'h2b8f9e52;
  int sd_blk;
  int rd_ptr;
  int wr_ptr;
  int act;
  logic rd_open;
  logic wr_open;
  int run_cycles;
  int errors;
  int checks;
  int tests;
  int err_mark;
  string test_name;
  logic aborted;

  sd_autotest #(
    .IN1_BYTES      (4),
    .IN2_BYTES      (4),
    .OUT_BYTES      (4),
    .TIMEOUT_CYCLES (TIMEOUT)
  ) i_sd_autotest (
    .clk              (clk),
    .rst              (rst),
    .spi_busy_i       (spi_busy_i),
    .spi_data_out_i   (spi_data_out_i),
    .spi_cmd_o        (spi_cmd_o),
    .spi_block_addr_o (spi_block_addr_o),
    .spi_data_in_o    (spi_data_in_o),
    .rst_uut_o        (rst_uut_o),
    .end_uut_i        (end_uut_i),
    .err_uut_i        (err_uut_i),
    .uut_in_1_o       (uut_in_1_o),
    .uut_in_2_o       (uut_in_2_o),
    .uut_out_i        (uut_out_i),
    .error_count_o    (error_count_o),
    .halted_o         (halted_o)
  );

  always #4 clk = ~clk;

  // uut is an adder
  assign uut_out_i = uut_in_1_o + uut_in_2_o;

  function automatic int block_index();
    logic [31:0] rel;
    rel = spi_block_addr_o - autotest_pkg::START_BLOCK;
    if (rel < 32'(NUM_BLOCKS)) return int'(rel);
    return -1;
  endfunction

  // busy rises two cycles after the strobe, falls 1 to 4 cycles later
  task automatic busy_handshake(input logic read_byte);
    int n;
    @(posedge clk);
    #1 spi_busy_i = 1'b1;
    n = 1 + ($unsigned($random(seed)) % 4);
    repeat (n) @(posedge clk);
    #1;
    if (read_byte && sd_blk >= 0) begin
      spi_data_out_i = card[sd_blk][rd_ptr];
      rd_ptr = rd_ptr + 1;
    end
    spi_busy_i = 1'b0;
  endtask

  // sd card behind the spi host
  always @(posedge clk) begin
    if (!spi_cmd_o.r_block) rd_open = 1'b0;
    if (!spi_cmd_o.w_block) wr_open = 1'b0;
    if (rst) act = ACT_NONE;
    else if (spi_cmd_o.rst) act = ACT_RESET;
    else if (spi_cmd_o.r_byte) act = ACT_RBYTE;
    else if (spi_cmd_o.w_byte) act = ACT_WBYTE;
    else if (spi_cmd_o.r_block && !rd_open) act = ACT_RBLOCK;
    else if (spi_cmd_o.w_block && !wr_open) act = ACT_WBLOCK;
    else act = ACT_NONE;
    if (act == ACT_RBLOCK) begin
      rd_open = 1'b1;
      sd_blk = block_index();
      rd_ptr = 0;
    end else if (act == ACT_WBLOCK) begin
      wr_open = 1'b1;
      sd_blk = block_index();
      wr_ptr = 0;
    end else if (act == ACT_WBYTE && sd_blk >= 0 && wr_ptr < BLK_BYTES) begin
      wr_mem[sd_blk][wr_ptr] = spi_data_in_o;
      wr_ptr = wr_ptr + 1;
      wr_cnt[sd_blk] = wr_cnt[sd_blk] + 1;
    end
    if (act != ACT_NONE) busy_handshake(act == ACT_RBYTE);
  end

  // uut ends or fails 5 cycles after its reset drops, or hangs
  always @(posedge clk) begin
    #1;
    end_uut_i = 1'b0;
    err_uut_i = 1'b0;
    if (rst_uut_o) begin
      run_cycles = 0;
    end else begin
      run_cycles = run_cycles + 1;
      if (run_cycles == 5 && block_index() >= 0) begin
        if (uut_mode[block_index()] == MODE_END) end_uut_i = 1'b1;
        else if (uut_mode[block_index()] == MODE_ERR) err_uut_i = 1'b1;
      end
    end
  end

  task automatic fill_block(input int b, input logic [31:0] sig, input logic [31:0] in1,
                            input logic [31:0] in2, input logic [31:0] exp, input int mode);
    int i;
    for (i = 0; i < BLK_BYTES; i++) begin
      card[b][i] = 8'(i ^ (i >> 8) ^ (b * 37));
      wr_mem[b][i] = 8'h00;
    end
    for (i = 0; i < 4; i++) begin
      card[b][i] = sig[8*(3-i) +: 8];
      card[b][4+i] = in1[8*i +: 8];
      card[b][8+i] = in2[8*i +: 8];
      card[b][12+i] = exp[8*i +: 8];
    end
    blk_in1[b] = in1;
    blk_in2[b] = in2;
    blk_exp[b] = exp;
    uut_mode[b] = mode;
    wr_cnt[b] = 0;
  endtask

  task automatic expect_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [63:0] written_le(input int b, input int off, input int len);
    logic [63:0] v;
    int i;
    v = '0;
    for (i = 0; i < len; i++) v[8*i +: 8] = wr_mem[b][off+i];
    return v;
  endfunction

  task automatic check_record(input int b, input logic [63:0] min_cycles);
    logic [63:0] cycles;
    int i;
    int bad_pad;
    expect_value("write byte count", 64'(wr_cnt[b]), 64'(BLK_BYTES));
    for (i = 0; i < 4; i++) begin
      expect_value("record signature byte", 64'(wr_mem[b][i]),
                   64'(autotest_pkg::SIGNATURE[8*(3-i) +: 8]));
    end
    expect_value("record input 1", written_le(b, 4, 4), 64'(blk_in1[b]));
    expect_value("record input 2", written_le(b, 8, 4), 64'(blk_in2[b]));
    expect_value("record expected", written_le(b, 12, 4), 64'(blk_exp[b]));
    expect_value("record result", written_le(b, 16, 4), 64'(blk_in1[b] + blk_in2[b]));
    cycles = written_le(b, 20, 8);
    checks++;
    assert (cycles >= min_cycles) else begin
      $display("Fail record exec_cycles: got 0x%0h expected at least 0x%0h",
               cycles, min_cycles);
      errors++;
    end
    bad_pad = 0;
    for (i = 28; i < BLK_BYTES; i++) begin
      if (wr_mem[b][i] !== autotest_pkg::PAD_BYTE) bad_pad++;
    end
    checks++;
    assert (bad_pad == 0) else begin
      $display("record of block %0d has %0d padding bytes that are not ff", b, bad_pad);
      errors++;
    end
  endtask

  // waits for a new read block command and checks its address
  task automatic wait_read_block(input logic [31:0] addr);
    int n;
    logic prev;
    prev = spi_cmd_o.r_block;
    for (n = 0; n < WAIT_LIMIT; n++) begin
      @(posedge clk);
      if (spi_cmd_o.r_block && !prev) break;
      prev = spi_cmd_o.r_block;
    end
    if (n == WAIT_LIMIT) begin
      $display("no read of block 0x%0h started within %0d cycles", addr, WAIT_LIMIT);
      errors++;
      aborted = 1'b1;
    end else begin
      expect_value("spi_block_addr_o", 64'(spi_block_addr_o), 64'(addr));
    end
  endtask

  task automatic begin_test(input string name);
    tests++;
    test_name = name;
    err_mark = errors;
  endtask

  task automatic end_test();
    $display("test %0d %s: %0d errors", tests, test_name, errors - err_mark);
  endtask

  task automatic run_tests();
    int n;
    int quiet_bad;
    begin_test("reset values and first block");
    expect_value("spi_cmd_o", 64'(spi_cmd_o), 64'h0);
    expect_value("rst_uut_o", 64'(rst_uut_o), 64'h1);
    expect_value("error_count_o", 64'(error_count_o), 64'h0);
    expect_value("halted_o", 64'(halted_o), 64'h0);
    #1 rst = 1'b0;
    wait_read_block(autotest_pkg::START_BLOCK);
    end_test();
    if (aborted) return;

    begin_test("passing block");
    wait_read_block(autotest_pkg::START_BLOCK + 32'd1);
    expect_value("block 0 write count", 64'(wr_cnt[0]), 64'h0);
    expect_value("error_count_o", 64'(error_count_o), 64'h0);
    end_test();
    if (aborted) return;

    begin_test("wrong expected value");
    wait_read_block(autotest_pkg::START_BLOCK + 32'd2);
    expect_value("error_count_o", 64'(error_count_o), 64'h1);
    check_record(1, 64'd5);
    end_test();
    if (aborted) return;

    begin_test("uut error and uut hang");
    wait_read_block(autotest_pkg::START_BLOCK + 32'd3);
    expect_value("error_count_o", 64'(error_count_o), 64'h2);
    check_record(2, 64'd5);
    wait_read_block(autotest_pkg::START_BLOCK + 32'd4);
    expect_value("error_count_o", 64'(error_count_o), 64'h3);
    check_record(3, 64'(TIMEOUT));
    end_test();
    if (aborted) return;

    begin_test("wrong signature halts");
    for (n = 0; n < WAIT_LIMIT && !halted_o; n++) @(posedge clk);
    if (!halted_o) begin
      $display("halted_o did not rise within %0d cycles", WAIT_LIMIT);
      errors++;
      aborted = 1'b1;
    end else begin
      quiet_bad = 0;
      for (n = 0; n < 1000; n++) begin
        @(posedge clk);
        if (spi_cmd_o != '0 || !rst_uut_o || !halted_o) quiet_bad++;
      end
      checks++;
      assert (quiet_bad == 0) else begin
        $display("sequencer was active in %0d cycles after halting", quiet_bad);
        errors++;
      end
      expect_value("error_count_o", 64'(error_count_o), 64'h3);
      expect_value("block 4 write count", 64'(wr_cnt[4]), 64'h0);
    end
    end_test();
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    spi_busy_i = 1'b0;
    spi_data_out_i = 8'h00;
    end_uut_i = 1'b0;
    err_uut_i = 1'b0;
    rd_open = 1'b0;
    wr_open = 1'b0;
    sd_blk = -1;
    rd_ptr = 0;
    wr_ptr = 0;
    run_cycles = 0;
    errors = 0;
    checks = 0;
    tests = 0;
    aborted = 1'b0;
    fill_block(0, autotest_pkg::SIGNATURE, 32'h1234_5678, 32'h0101_0101, 32'h1335_5779,
               MODE_END);
    fill_block(1, autotest_pkg::SIGNATURE, 32'h0000_00FF, 32'h0000_0001, 32'h0000_0000,
               MODE_END);
    fill_block(2, autotest_pkg::SIGNATURE, 32'hCAFE_0000, 32'h0000_BEEF, 32'hCAFE_BEEF,
               MODE_ERR);
    fill_block(3, autotest_pkg::SIGNATURE, 32'h0000_0007, 32'h0000_0009, 32'h0000_0010,
               MODE_HANG);
    fill_block(4, 32'hAABB_CCDE, 32'h0000_0001, 32'h0000_0002, 32'h0000_0003, MODE_END);
    repeat (8) @(posedge clk);
    run_tests();
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0 && !aborted) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/sd_autotest_sva.sv */
// concurrent checks on the spi command, block address, uut reset and status
// outputs of sd_autotest, attached with bind
`timescale 1ns/1ps
`default_nettype none

module sd_autotest_sva (
  input wire logic                       clk,
  input wire logic                       rst,
  input wire autotest_pkg::spi_cmd_t     spi_cmd_i,
  input wire logic [31:0]                block_addr_i,
  input wire logic [31:0]                error_count_i,
  input wire logic                       halted_i,
  input wire logic                       rst_uut_i,
  input wire autotest_pkg::seq_state_t   state_i
);

  a_wbyte_in_block: assert property (@(posedge clk) disable iff (rst)
    spi_cmd_i.w_byte |-> spi_cmd_i.w_block)
    else $error("w_byte raised outside a write block");

  a_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(spi_cmd_i.r_block && spi_cmd_i.w_block))
    else $error("read and write block commands overlap");

  a_count_monotonic: assert property (@(posedge clk) disable iff (rst)
    error_count_i >= $past(error_count_i))
    else $error("error count decreased");

  a_addr_step: assert property (@(posedge clk) disable iff (rst)
    $changed(block_addr_i) |-> (block_addr_i == $past(block_addr_i) + 32'd1))
    else $error("block address moved by other than one");

  a_halted_sticky: assert property (@(posedge clk)
    $fell(halted_i) |-> rst)
    else $error("halted dropped without reset");

  // uut only runs while the sequencer waits for it
  a_uut_held: assert property (@(posedge clk) disable iff (rst)
    (state_i != autotest_pkg::RUN_TEST) |-> rst_uut_i)
    else $error("uut released outside a test run");

endmodule

bind sd_autotest sd_autotest_sva i_sd_autotest_sva (
  .clk           (clk),
  .rst           (rst),
  .spi_cmd_i     (spi_cmd_o),
  .block_addr_i  (spi_block_addr_o),
  .error_count_i (error_count_o),
  .halted_i      (halted_o),
  .rst_uut_i     (rst_uut_o),
  .state_i       (i_test_sequencer.state_q)
);

`default_nettype wire

/* rtl/sd_autotest.sv */
// top level of the sd card self-test sequencer
// vector loader and run timer side by side, combined by the sequencer
`timescale 1ns/1ps
`default_nettype none

module sd_autotest #(
  parameter int              IN1_BYTES      = 4,
  parameter int              IN2_BYTES      = 4,
  parameter int              OUT_BYTES      = 4,
  parameter longint unsigned TIMEOUT_CYCLES = 64'h1000_0000
) (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   spi_busy_i,
  input  wire logic [7:0]             spi_data_out_i,
  output autotest_pkg::spi_cmd_t      spi_cmd_o,
  output logic [31:0]                 spi_block_addr_o,
  output logic [7:0]                  spi_data_in_o,
  output logic                        rst_uut_o,
  input  wire logic                   end_uut_i,
  input  wire logic                   err_uut_i,
  output logic [IN1_BYTES*8-1:0]      uut_in_1_o,
  output logic [IN2_BYTES*8-1:0]      uut_in_2_o,
  input  wire logic [OUT_BYTES*8-1:0] uut_out_i,
  output logic [31:0]                 error_count_o,
  output logic                        halted_o
);

  logic                   load_clr;
  logic                   byte_we;
  logic [9:0]             byte_idx;
  logic                   sig_ok;
  logic [OUT_BYTES*8-1:0] expected;
  logic                   run_start;
  logic                   run_clr;
  logic                   run_done;
  logic                   run_err;
  logic [OUT_BYTES*8-1:0] result;
  logic [63:0]            exec_cycles;

  vector_loader #(
    .IN1_BYTES(IN1_BYTES),
    .IN2_BYTES(IN2_BYTES),
    .OUT_BYTES(OUT_BYTES)
  ) i_vector_loader (
    .clk        (clk),
    .rst        (rst),
    .load_clr_i (load_clr),
    .byte_we_i  (byte_we),
    .byte_idx_i (byte_idx),
    .byte_i     (spi_data_out_i),
    .in1_o      (uut_in_1_o),
    .in2_o      (uut_in_2_o),
    .expected_o (expected),
    .sig_ok_o   (sig_ok)
  );

  uut_run_timer #(
    .OUT_BYTES     (OUT_BYTES),
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) i_uut_run_timer (
    .clk           (clk),
    .rst           (rst),
    .clr_i         (run_clr),
    .start_i       (run_start),
    .end_uut_i     (end_uut_i),
    .err_uut_i     (err_uut_i),
    .uut_out_i     (uut_out_i),
    .rst_uut_o     (rst_uut_o),
    .done_o        (run_done),
    .run_err_o     (run_err),
    .result_o      (result),
    .exec_cycles_o (exec_cycles)
  );

  test_sequencer #(
    .IN1_BYTES(IN1_BYTES),
    .IN2_BYTES(IN2_BYTES),
    .OUT_BYTES(OUT_BYTES)
  ) i_test_sequencer (
    .clk              (clk),
    .rst              (rst),
    .spi_busy_i       (spi_busy_i),
    .spi_cmd_o        (spi_cmd_o),
    .spi_block_addr_o (spi_block_addr_o),
    .spi_data_in_o    (spi_data_in_o),
    .load_clr_o       (load_clr),
    .byte_we_o        (byte_we),
    .byte_idx_o       (byte_idx),
    .sig_ok_i         (sig_ok),
    .in1_i            (uut_in_1_o),
    .in2_i            (uut_in_2_o),
    .expected_i       (expected),
    .run_start_o      (run_start),
    .run_clr_o        (run_clr),
    .run_done_i       (run_done),
    .run_err_i        (run_err),
    .result_i         (result),
    .exec_cycles_i    (exec_cycles),
    .error_count_o    (error_count_o),
    .halted_o         (halted_o)
  );

endmodule

`default_nettype wire

/* rtl/test_sequencer.sv */
// block sequencing fsm with byte, block and error counters,
// pass/fail decision and failure record serialization
`timescale 1ns/1ps
`default_nettype none

module test_sequencer #(
  parameter int IN1_BYTES = 4,
  parameter int IN2_BYTES = 4,
  parameter int OUT_BYTES = 4
) (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   spi_busy_i,
  output autotest_pkg::spi_cmd_t      spi_cmd_o,
  output logic [31:0]                 spi_block_addr_o,
  output logic [7:0]                  spi_data_in_o,
  output logic                        load_clr_o,
  output logic                        byte_we_o,
  output logic [9:0]                  byte_idx_o,
  input  wire logic                   sig_ok_i,
  input  wire logic [IN1_BYTES*8-1:0] in1_i,
  input  wire logic [IN2_BYTES*8-1:0] in2_i,
  input  wire logic [OUT_BYTES*8-1:0] expected_i,
  output logic                        run_start_o,
  output logic                        run_clr_o,
  input  wire logic                   run_done_i,
  input  wire logic                   run_err_i,
  input  wire logic [OUT_BYTES*8-1:0] result_i,
  input  wire logic [63:0]            exec_cycles_i,
  output logic [31:0]                 error_count_o,
  output logic                        halted_o
);

  // record field offsets
  localparam int OFF_IN1  = autotest_pkg::SIG_BYTES;
  localparam int OFF_IN2  = OFF_IN1 + IN1_BYTES;
  localparam int OFF_EXP  = OFF_IN2 + IN2_BYTES;
  localparam int OFF_RES  = OFF_EXP + OUT_BYTES;
  localparam int OFF_TIME = OFF_RES + OUT_BYTES;
  localparam int OFF_PAD  = OFF_TIME + autotest_pkg::TIME_BYTES;
  localparam logic [9:0] LAST_BYTE = 10'(autotest_pkg::BLOCK_BYTES - 1);

  autotest_pkg::seq_state_t state_q;
  autotest_pkg::seq_state_t state_d;
  logic [9:0] byte_cnt_q;
  logic [9:0] rel;
  logic [7:0] rec_byte;
  logic       fail;

  assign fail = run_err_i || (result_i != expected_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      autotest_pkg::INIT:           state_d = autotest_pkg::SPI_RESET;
      autotest_pkg::SPI_RESET:      if (spi_busy_i) state_d = autotest_pkg::WAIT_SPI_RESET;
      autotest_pkg::WAIT_SPI_RESET: if (!spi_busy_i) state_d = autotest_pkg::IDLE;
      autotest_pkg::IDLE:           state_d = autotest_pkg::SEL_BLOCK;
      autotest_pkg::SEL_BLOCK:      if (spi_busy_i) state_d = autotest_pkg::WAIT_BLOCK;
      autotest_pkg::WAIT_BLOCK:     if (!spi_busy_i) state_d = autotest_pkg::READ_BYTE;
      autotest_pkg::READ_BYTE:      if (spi_busy_i) state_d = autotest_pkg::WAIT_BYTE;
      autotest_pkg::WAIT_BYTE:      if (!spi_busy_i) state_d = autotest_pkg::READ_DATA;
      autotest_pkg::READ_DATA: begin
        if (byte_cnt_q == LAST_BYTE) state_d = autotest_pkg::CHECK_SIG;
        else state_d = autotest_pkg::READ_BYTE;
      end
      autotest_pkg::CHECK_SIG: begin
        if (sig_ok_i) state_d = autotest_pkg::START_TEST;
        else state_d = autotest_pkg::HALT;
      end
      autotest_pkg::START_TEST:     state_d = autotest_pkg::RUN_TEST;
      autotest_pkg::RUN_TEST:       if (run_done_i) state_d = autotest_pkg::COMPARE;
      autotest_pkg::COMPARE: begin
        if (fail) state_d = autotest_pkg::SEL_W_BLOCK;
        else state_d = autotest_pkg::NEXT_BLOCK;
      end
      autotest_pkg::SEL_W_BLOCK:    if (spi_busy_i) state_d = autotest_pkg::WAIT_W_BLOCK;
      autotest_pkg::WAIT_W_BLOCK:   if (!spi_busy_i) state_d = autotest_pkg::WRITE_DATA;
      autotest_pkg::WRITE_DATA:     if (spi_busy_i) state_d = autotest_pkg::WAIT_W_BYTE;
      autotest_pkg::WAIT_W_BYTE: begin
        if (!spi_busy_i) begin
          if (byte_cnt_q == 10'(autotest_pkg::BLOCK_BYTES)) state_d = autotest_pkg::NEXT_BLOCK;
          else state_d = autotest_pkg::WRITE_DATA;
        end
      end
      autotest_pkg::NEXT_BLOCK:     if (!spi_busy_i) state_d = autotest_pkg::IDLE;
      autotest_pkg::HALT:           state_d = autotest_pkg::HALT;
      default:                      state_d = autotest_pkg::INIT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q          <= autotest_pkg::INIT;
      byte_cnt_q       <= '0;
      spi_block_addr_o <= autotest_pkg::START_BLOCK;
      error_count_o    <= '0;
    end else begin
      state_q <= state_d;
      case (state_q)
        autotest_pkg::IDLE, autotest_pkg::COMPARE: byte_cnt_q <= '0;
        autotest_pkg::READ_DATA: byte_cnt_q <= byte_cnt_q + 10'd1;
        // write side advances as soon as the host takes the byte
        autotest_pkg::WRITE_DATA: if (spi_busy_i) byte_cnt_q <= byte_cnt_q + 10'd1;
        default: ;
      endcase
      if (state_q == autotest_pkg::COMPARE && fail) begin
        error_count_o <= error_count_o + 32'd1;
      end
      if (state_q == autotest_pkg::NEXT_BLOCK && !spi_busy_i) begin
        spi_block_addr_o <= spi_block_addr_o + 32'd1;
      end
    end
  end

  // failure record byte for the current offset
  always_comb begin
    rel = '0;
    rec_byte = autotest_pkg::PAD_BYTE;
    if (byte_cnt_q < 10'(OFF_IN1)) begin
      rel = 10'(OFF_IN1 - 1) - byte_cnt_q;
      rec_byte = 8'(autotest_pkg::SIGNATURE >> (8 * rel));
    end else if (byte_cnt_q < 10'(OFF_IN2)) begin
      rel = byte_cnt_q - 10'(OFF_IN1);
      rec_byte = 8'(in1_i >> (8 * rel));
    end else if (byte_cnt_q < 10'(OFF_EXP)) begin
      rel = byte_cnt_q - 10'(OFF_IN2);
      rec_byte = 8'(in2_i >> (8 * rel));
    end else if (byte_cnt_q < 10'(OFF_RES)) begin
      rel = byte_cnt_q - 10'(OFF_EXP);
      rec_byte = 8'(expected_i >> (8 * rel));
    end else if (byte_cnt_q < 10'(OFF_TIME)) begin
      rel = byte_cnt_q - 10'(OFF_RES);
      rec_byte = 8'(result_i >> (8 * rel));
    end else if (byte_cnt_q < 10'(OFF_PAD)) begin
      rel = byte_cnt_q - 10'(OFF_TIME);
      rec_byte = 8'(exec_cycles_i >> (8 * rel));
    end
  end

  // loaded only while w_byte is low
  always_ff @(posedge clk) begin
    if (state_q == autotest_pkg::WAIT_W_BLOCK || state_q == autotest_pkg::WAIT_W_BYTE) begin
      spi_data_in_o <= rec_byte;
    end
  end

  always_comb begin
    spi_cmd_o = '0;
    spi_cmd_o.rst = (state_q == autotest_pkg::SPI_RESET);
    spi_cmd_o.r_block = state_q inside {autotest_pkg::SEL_BLOCK, autotest_pkg::WAIT_BLOCK,
                                        autotest_pkg::READ_BYTE, autotest_pkg::WAIT_BYTE,
                                        autotest_pkg::READ_DATA};
    spi_cmd_o.r_byte = (state_q == autotest_pkg::READ_BYTE);
    spi_cmd_o.w_block = state_q inside {autotest_pkg::SEL_W_BLOCK, autotest_pkg::WAIT_W_BLOCK,
                                        autotest_pkg::WRITE_DATA, autotest_pkg::WAIT_W_BYTE};
    spi_cmd_o.w_byte = (state_q == autotest_pkg::WRITE_DATA);
  end

  assign load_clr_o  = (state_q == autotest_pkg::IDLE);
  assign run_clr_o   = (state_q == autotest_pkg::IDLE);
  assign byte_we_o   = (state_q == autotest_pkg::READ_DATA);
  assign byte_idx_o  = byte_cnt_q;
  assign run_start_o = (state_q == autotest_pkg::START_TEST);
  assign halted_o    = (state_q == autotest_pkg::HALT);

endmodule

`default_nettype wire

/* rtl/uut_run_timer.sv */
// uut run control with execution-cycle counter, timeout and result capture
`timescale 1ns/1ps
`default_nettype none

module uut_run_timer #(
  parameter int              OUT_BYTES      = 4,
  parameter longint unsigned TIMEOUT_CYCLES = 64'h1000_0000
) (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   clr_i,
  input  wire logic                   start_i,
  input  wire logic                   end_uut_i,
  input  wire logic                   err_uut_i,
  input  wire logic [OUT_BYTES*8-1:0] uut_out_i,
  output logic                        rst_uut_o,
  output logic                        done_o,
  output logic                        run_err_o,
  output logic [OUT_BYTES*8-1:0]      result_o,
  output logic [63:0]                 exec_cycles_o
);

  logic        running_q;
  logic [63:0] next_cycles;
  logic        stop;

  assign next_cycles = exec_cycles_o + 64'd1;
  assign stop = end_uut_i || err_uut_i || (next_cycles >= TIMEOUT_CYCLES);

  always_ff @(posedge clk) begin
    if (rst || clr_i) begin
      running_q     <= 1'b0;
      done_o        <= 1'b0;
      run_err_o     <= 1'b0;
      result_o      <= '0;
      exec_cycles_o <= '0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        running_q     <= 1'b1;
        exec_cycles_o <= '0;
      end else if (running_q) begin
        exec_cycles_o <= next_cycles;
        if (stop) begin
          running_q <= 1'b0;
          done_o    <= 1'b1;
          result_o  <= uut_out_i;
          // a timeout without end also counts as an error
          run_err_o <= err_uut_i || !end_uut_i;
        end
      end
    end
  end

  // uut held in reset whenever no run is active
  assign rst_uut_o = !running_q;

endmodule

`default_nettype wire

/* rtl/vector_loader.sv */
// byte-wise capture of signature, uut input vectors and expected result
// from an sd block, plus the signature check
`timescale 1ns/1ps
`default_nettype none

module vector_loader #(
  parameter int IN1_BYTES = 4,
  parameter int IN2_BYTES = 4,
  parameter int OUT_BYTES = 4
) (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   load_clr_i,
  input  wire logic                   byte_we_i,
  input  wire logic [9:0]             byte_idx_i,
  input  wire logic [7:0]             byte_i,
  output logic [IN1_BYTES*8-1:0]      in1_o,
  output logic [IN2_BYTES*8-1:0]      in2_o,
  output logic [OUT_BYTES*8-1:0]      expected_o,
  output logic                        sig_ok_o
);

  // field offsets inside the block
  localparam int OFF_IN1 = autotest_pkg::SIG_BYTES;
  localparam int OFF_IN2 = OFF_IN1 + IN1_BYTES;
  localparam int OFF_EXP = OFF_IN2 + IN2_BYTES;
  localparam int OFF_END = OFF_EXP + OUT_BYTES;

  logic [31:0] sig_q;
  logic [9:0]  rel_sig;
  logic [9:0]  rel_in1;
  logic [9:0]  rel_in2;
  logic [9:0]  rel_exp;

  // signature arrives msb first, vectors lsb byte first
  assign rel_sig = 10'(OFF_IN1 - 1) - byte_idx_i;
  assign rel_in1 = byte_idx_i - 10'(OFF_IN1);
  assign rel_in2 = byte_idx_i - 10'(OFF_IN2);
  assign rel_exp = byte_idx_i - 10'(OFF_EXP);

  always_ff @(posedge clk) begin
    if (rst || load_clr_i) begin
      sig_q      <= '0;
      in1_o      <= '0;
      in2_o      <= '0;
      expected_o <= '0;
    end else if (byte_we_i) begin
      if (byte_idx_i < 10'(OFF_IN1)) begin
        sig_q[8*rel_sig +: 8] <= byte_i;
      end else if (byte_idx_i < 10'(OFF_IN2)) begin
        in1_o[8*rel_in1 +: 8] <= byte_i;
      end else if (byte_idx_i < 10'(OFF_EXP)) begin
        in2_o[8*rel_in2 +: 8] <= byte_i;
      end else if (byte_idx_i < 10'(OFF_END)) begin
        expected_o[8*rel_exp +: 8] <= byte_i;
      end
      // rest of the block is ignored
    end
  end

  assign sig_ok_o = (sig_q == autotest_pkg::SIGNATURE);

endmodule

`default_nettype wire

/* rtl/autotest_pkg.sv */
// shared constants, spi host command struct and sequencer state enum
// for the sd card driven self-test sequencer
`default_nettype none

package autotest_pkg;

  // key a block must carry before its test is run
  localparam logic [31:0] SIGNATURE = 32'hAABB_CCDD;

  // first sd block holding a test record
  localparam logic [31:0] START_BLOCK = 32'h0010_0000;

  localparam int BLOCK_BYTES = 512;
  localparam int SIG_BYTES = 4;
  localparam int TIME_BYTES = 8;

  // filler after the failure record
  localparam logic [7:0] PAD_BYTE = 8'hFF;

  // level commands towards the spi host
  typedef struct packed {
    logic rst;
    logic r_block;
    logic r_byte;
    logic w_block;
    logic w_byte;
  } spi_cmd_t;

  typedef enum logic [4:0] {
    INIT,
    SPI_RESET,
    WAIT_SPI_RESET,
    IDLE,
    SEL_BLOCK,
    WAIT_BLOCK,
    READ_DATA,
    READ_BYTE,
    WAIT_BYTE,
    CHECK_SIG,
    START_TEST,
    RUN_TEST,
    COMPARE,
    SEL_W_BLOCK,
    WAIT_W_BLOCK,
    WRITE_DATA,
    WAIT_W_BYTE,
    NEXT_BLOCK,
    HALT
  } seq_state_t;

endpackage

`default_nettype wire
